// File: capture_replay.f
verilog/replay_pkg.sv
verilog/record_writer.sv
verilog/replay_sequencer.sv
verilog/word_store.sv
verilog/stream_unpacker.sv
verilog/capture_replay_top.sv
verification/capture_replay_sva.sv
verification/capture_replay_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module capture_replay_tb -f capture_replay.f -o capture_replay_sim; then
   echo "build failed"
   exit 1
fi

if ! ./obj_dir/capture_replay_sim +verilator+error+limit+1000 > "$LOG" 2>&1; then
   cat "$LOG"
   echo "simulation exited with an error status"
   exit 1
fi
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
   exit 1
fi
exit 0

// File: verification/capture_replay_sva.sv
// ========================================
// Stream protocol and reset assertions
// for the record and replay top level,
// bound into every instance of it.
// ========================================
`default_nettype none

module capture_replay_sva (
   input wire                          clk,
   input wire                          rst_clk,
   input wire                          in_ready_i,
   input wire                          busy_i,
   input wire replay_pkg::pkt_beat_t   out_beat_i,
   input wire                          out_valid_i,
   input wire                          out_ready_i,
   input wire                          wr_valid_i,
   input wire                          rd_valid_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // a stalled output beat stays put until the sink takes it
   hold_beat: assert property (@(posedge clk) disable iff (rst_clk)
         (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_beat_i)))
      else begin
         $error("out_beat_o changed or dropped while stalled");
         fail_count++;
      end

   // recording is shut off for the whole replay
   no_input_in_replay: assert property (@(posedge clk) disable iff (rst_clk)
         busy_i |-> !in_ready_i)
      else begin
         $error("in_ready_o high while busy_o is high");
         fail_count++;
      end

   quiet_after_reset: assert property (@(posedge clk)
         rst_clk |=> (!busy_i && !in_ready_i && !out_valid_i && !wr_valid_i && !rd_valid_i))
      else begin
         $error("busy or a valid is high in the cycle after reset");
         fail_count++;
      end

endmodule

bind capture_replay_top capture_replay_sva capture_replay_sva_inst (
   .clk         (clk),
   .rst_clk     (rst_clk),
   .in_ready_i  (in_ready_o),
   .busy_i      (busy_o),
   .out_beat_i  (out_beat_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .wr_valid_i  (wr_valid),
   .rd_valid_i  (rd_valid)
);

`default_nettype wire

// File: verification/capture_replay_tb.sv
// ========================================
// Testbench for the record and replay
// engine. Each table entry records a set
// of packets, replays it a number of
// times and compares the output stream
// with a model of the stored words.
// ========================================
`default_nettype none

module capture_replay_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_TESTS = 5;
   localparam int MAX_PKTS  = 8;

   // lens[0] is the first packet of the entry
   typedef struct packed {
      logic [MAX_PKTS-1:0][7:0]  lens;
      logic [3:0]                npkt;
      logic [127:0]              user;
      logic [7:0]                passes;
      logic                      clear_first;
      logic                      backpressure;
   } test_entry_t;

   logic                             clk;
   logic                             rst_clk;
   logic                             clear_i;
   replay_pkg::pkt_beat_t            in_beat_i;
   logic                             in_valid_i;
   logic                             in_ready_o;
   logic                             start_i;
   logic [replay_pkg::PASS_W-1:0]    pass_count_i;
   logic                             busy_o;
   logic [31:0]                      pkt_count_o;
   replay_pkg::pkt_beat_t            out_beat_o;
   logic                             out_valid_o;
   logic                             out_ready_i;

   test_entry_t                      test_table [NUM_TESTS];
   string                            test_name [NUM_TESTS];
   logic                             table_loaded;
   logic [31:0]                      lfsr_q;
   int                               errors;
   int                               checks;
   int                               failed_tests;

   // what the store should hold since the last clear
   replay_pkg::pkt_beat_t            stim_q [$];
   replay_pkg::pkt_beat_t            rec_q [$];
   int                               mdl_addr;
   logic                             mdl_flush;
   int                               mdl_pkts;

   capture_replay_top capture_replay_top_inst (
      .clk          (clk),
      .rst_clk      (rst_clk),
      .clear_i      (clear_i),
      .in_beat_i    (in_beat_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .start_i      (start_i),
      .pass_count_i (pass_count_i),
      .busy_o       (busy_o),
      .pkt_count_o  (pkt_count_o),
      .out_beat_o   (out_beat_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1, stepped once per bit
   function automatic logic lfsr_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic logic [127:0] random_bits(input int n);
      logic [127:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[126:0], lfsr_bit()};
      end
      return val;
   endfunction

   function automatic test_entry_t make_entry(input logic [63:0] lens, input int npkt,
                                              input logic [127:0] user, input int passes,
                                              input logic clear_first, input logic backpressure);
      test_entry_t e;
      e.lens         = lens;
      e.npkt         = npkt[3:0];
      e.user         = user;
      e.passes       = passes[7:0];
      e.clear_first  = clear_first;
      e.backpressure = backpressure;
      return e;
   endfunction

   function automatic void load_table();
      test_name[0]  = "single packet";
      test_table[0] = make_entry(64'h0000000000000004, 1, 128'h5eed_0001, 1, 1'b1, 1'b0);
      test_name[1]  = "mixed packets";
      test_table[1] = make_entry(64'h0000000502060301, 5, 128'ha0a0_1000, 3, 1'b1, 1'b0);
      // appends to the previous recording
      test_name[2]  = "back-pressure";
      test_table[2] = make_entry(64'h0000000000000702, 2, 128'hbeef_2000, 2, 1'b0, 1'b1);
      test_name[3]  = "overflow";
      test_table[3] = make_entry(64'h0000030e0e0e0e0e, 6, 128'hc0de_3000, 2, 1'b1, 1'b0);
      test_name[4]  = "clear and record";
      test_table[4] = make_entry(64'h0000000000040103, 3, 128'hf00d_4000, 2, 1'b1, 1'b1);
   endfunction

   // header word first, then one word per beat, and the top word closes the recording
   function automatic void model_beat(input replay_pkg::pkt_beat_t beat, input logic first);
      replay_pkg::pkt_beat_t exp;
      if (first && !mdl_flush) begin
         if (mdl_addr == replay_pkg::DEPTH - 1) begin
            mdl_flush = 1'b1;
         end else begin
            mdl_addr++;
            mdl_pkts++;
         end
      end
      if (!mdl_flush) begin
         exp = beat;
         if (!first) begin
            exp.user = '0;
         end
         if (mdl_addr == replay_pkg::DEPTH - 1) begin
            exp.last  = 1'b1;
            mdl_flush = 1'b1;
         end else begin
            mdl_addr++;
         end
         rec_q.push_back(exp);
      end
   endfunction

   function automatic void build_stimulus(input test_entry_t e);
      replay_pkg::pkt_beat_t beat;
      int len;
      int nbytes;
      stim_q.delete();
      for (int p = 0; p < int'(e.npkt); p++) begin
         len = int'(e.lens[p]);
         for (int b = 0; b < len; b++) begin
            beat.data = random_bits(128);
            nbytes    = int'(random_bits(4)) + 1;
            beat.keep = 16'hffff >> (16 - nbytes);
            beat.user = e.user + 128'(p);
            beat.last = (b == len - 1);
            stim_q.push_back(beat);
            model_beat(beat, b == 0);
         end
      end
   endfunction

   task automatic compare_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("%s", what);
         errors++;
      end
   endtask

   task automatic clear_recording();
      clear_i = 1'b1;
      @(posedge clk);
      #1;
      clear_i   = 1'b0;
      rec_q.delete();
      mdl_addr  = 0;
      mdl_flush = 1'b0;
      mdl_pkts  = 0;
   endtask

   // ready is sampled mid-cycle, so the edge that follows moves the beat
   task automatic drive_input();
      logic accepted;
      int   waited;
      foreach (stim_q[i]) begin
         in_beat_i  = stim_q[i];
         in_valid_i = 1'b1;
         accepted   = 1'b0;
         waited     = 0;
         while (!accepted && waited < 32) begin
            @(negedge clk);
            accepted = in_ready_o;
            @(posedge clk);
            #1;
            waited++;
         end
         expect_true(accepted, $sformatf("input beat %0d was not accepted", i));
      end
      in_valid_i = 1'b0;
      in_beat_i  = '0;
   endtask

   task automatic replay_and_check(input int passes, input logic backpressure);
      replay_pkg::pkt_beat_t exp_q [$];
      replay_pkg::pkt_beat_t got_q [$];
      int   limit;
      int   cycles;
      logic busy_seen;
      for (int n = 0; n < passes; n++) begin
         foreach (rec_q[i]) begin
            exp_q.push_back(rec_q[i]);
         end
      end
      limit        = exp_q.size() * 40 + 200;
      out_ready_i  = 1'b1;
      start_i      = 1'b1;
      pass_count_i = passes[replay_pkg::PASS_W-1:0];
      @(posedge clk);
      #1;
      start_i = 1'b0;
      @(negedge clk);
      expect_true(busy_o, "start was not taken, busy_o stayed low");
      busy_seen = busy_o;
      cycles    = 0;
      while ((got_q.size() < exp_q.size() || busy_seen) && cycles < limit) begin
         @(posedge clk);
         #1;
         out_ready_i = backpressure ? lfsr_bit() : 1'b1;
         @(negedge clk);
         if (out_valid_o && out_ready_i) begin
            got_q.push_back(out_beat_o);
         end
         busy_seen = busy_o;
         cycles++;
      end
      expect_true(!busy_seen && got_q.size() >= exp_q.size(),
                  $sformatf("replay did not finish within %0d cycles", limit));
      // extra beats would show up here
      repeat (8) begin
         @(posedge clk);
         #1;
         out_ready_i = 1'b1;
         @(negedge clk);
         if (out_valid_o) begin
            got_q.push_back(out_beat_o);
         end
      end
      expect_true(got_q.size() == exp_q.size(),
                  $sformatf("replay gave %0d beats, expected %0d", got_q.size(), exp_q.size()));
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
         compare_value($sformatf("out_beat_o.data[%0d]", i), got_q[i].data, exp_q[i].data);
         compare_value($sformatf("out_beat_o.keep[%0d]", i),
                       128'(got_q[i].keep), 128'(exp_q[i].keep));
         compare_value($sformatf("out_beat_o.user[%0d]", i), got_q[i].user, exp_q[i].user);
         compare_value($sformatf("out_beat_o.last[%0d]", i),
                       128'(got_q[i].last), 128'(exp_q[i].last));
      end
      @(posedge clk);
      #1;
   endtask

   initial begin
      int          total_beats;
      int          max_pass;
      int          limit;
      wait (table_loaded === 1'b1);
      total_beats = 0;
      max_pass    = 1;
      for (int t = 0; t < NUM_TESTS; t++) begin
         for (int p = 0; p < int'(test_table[t].npkt); p++) begin
            total_beats += int'(test_table[t].lens[p]);
         end
         if (int'(test_table[t].passes) > max_pass) begin
            max_pass = int'(test_table[t].passes);
         end
      end
      limit = total_beats * max_pass * 40 + 5000;
      repeat (limit) @(posedge clk);
      $display("timeout: the run did not end within %0d clock cycles", limit);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int          base_errors;
      int          sva_fails;
      test_entry_t e;
      table_loaded = 1'b0;
      rst_clk      = 1'b1;
      clear_i      = 1'b0;
      in_beat_i    = '0;
      in_valid_i   = 1'b0;
      start_i      = 1'b0;
      pass_count_i = '0;
      out_ready_i  = 1'b1;
      lfsr_q       = 32'he3bf52c8;
      errors       = 0;
      checks       = 0;
      failed_tests = 0;
      mdl_addr     = 0;
      mdl_flush    = 1'b0;
      mdl_pkts     = 0;
      load_table();
      table_loaded = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst_clk = 1'b0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         e           = test_table[t];
         base_errors = errors;
         if (e.clear_first) begin
            clear_recording();
         end
         build_stimulus(e);
         drive_input();
         @(negedge clk);
         compare_value("pkt_count_o", 128'(pkt_count_o), 128'(mdl_pkts));
         @(posedge clk);
         #1;
         replay_and_check(int'(e.passes), e.backpressure);
         if (errors == base_errors) begin
            $display("test %0d %s: ok, %0d beats per pass", t, test_name[t], rec_q.size());
         end else begin
            failed_tests++;
            $display("test %0d %s: FAIL, %0d errors", t, test_name[t], errors - base_errors);
         end
      end
      sva_fails = capture_replay_top_inst.capture_replay_sva_inst.fail_count;
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               NUM_TESTS, failed_tests, checks, errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/capture_replay_top.sv
// ======================================
// Top level of the record and replay
// engine. The recorder and the replay
// sequencer share the word store, whose
// read data feeds the stream unpacker.
// ======================================
`default_nettype none

module capture_replay_top (
   input  wire                             clk,
   input  wire                             rst_clk,
   input  wire                             clear_i,
   input  wire replay_pkg::pkt_beat_t      in_beat_i,
   input  wire                             in_valid_i,
   output logic                            in_ready_o,
   input  wire                             start_i,
   input  wire [replay_pkg::PASS_W-1:0]    pass_count_i,
   output logic                            busy_o,
   output logic [31:0]                     pkt_count_o,
   output replay_pkg::pkt_beat_t           out_beat_o,
   output logic                            out_valid_o,
   input  wire                             out_ready_i
);

   replay_pkg::wr_req_t              wr_req;
   logic                             wr_valid;
   logic [replay_pkg::ADDR_W-1:0]    rd_addr;
   logic                             rd_valid;
   logic                             rd_ready;
   replay_pkg::mem_word_t            rd_word;
   logic                             word_valid;
   logic                             word_room;
   logic [replay_pkg::ADDR_W-1:0]    end_addr;
   logic                             has_data;
   logic                             mid_packet;

   record_writer record_writer_inst (
      .clk           (clk),
      .rst_clk       (rst_clk),
      .clear_i       (clear_i),
      .in_beat_i     (in_beat_i),
      .in_valid_i    (in_valid_i),
      .in_ready_o    (in_ready_o),
      .replay_busy_i (busy_o),
      .wr_req_o      (wr_req),
      .wr_valid_o    (wr_valid),
      .end_addr_o    (end_addr),
      .has_data_o    (has_data),
      .mid_packet_o  (mid_packet),
      .pkt_count_o   (pkt_count_o)
   );

   replay_sequencer replay_sequencer_inst (
      .clk           (clk),
      .rst_clk       (rst_clk),
      .clear_i       (clear_i),
      .start_i       (start_i),
      .pass_count_i  (pass_count_i),
      .end_addr_i    (end_addr),
      .has_data_i    (has_data),
      .mid_packet_i  (mid_packet),
      .word_room_i   (word_room),
      .rd_ready_i    (rd_ready),
      .rd_addr_o     (rd_addr),
      .rd_valid_o    (rd_valid),
      .busy_o        (busy_o)
   );

   word_store word_store_inst (
      .clk           (clk),
      .wr_req_i      (wr_req),
      .wr_valid_i    (wr_valid),
      .rd_addr_i     (rd_addr),
      .rd_valid_i    (rd_valid),
      .rd_ready_o    (rd_ready),
      .rd_word_o     (rd_word),
      .word_valid_o  (word_valid)
   );

   stream_unpacker stream_unpacker_inst (
      .clk           (clk),
      .rst_clk       (rst_clk),
      .word_i        (rd_word),
      .word_valid_i  (word_valid),
      .word_room_o   (word_room),
      .out_beat_o    (out_beat_o),
      .out_valid_o   (out_valid_o),
      .out_ready_i   (out_ready_i)
   );

endmodule

`default_nettype wire

// File: verilog/record_writer.sv
// ======================================
// Recorder for the incoming stream. Each
// packet is written as one header word
// with the user field, then one word per
// beat. When the store is full the rest
// of the input is drained until clear.
// ======================================
`default_nettype none

module record_writer (
   input  wire                             clk,
   input  wire                             rst_clk,
   input  wire                             clear_i,
   input  wire replay_pkg::pkt_beat_t      in_beat_i,
   input  wire                             in_valid_i,
   output logic                            in_ready_o,
   input  wire                             replay_busy_i,
   output replay_pkg::wr_req_t             wr_req_o,
   output logic                            wr_valid_o,
   output logic [replay_pkg::ADDR_W-1:0]   end_addr_o,
   output logic                            has_data_o,
   output logic                            mid_packet_o,
   output logic [31:0]                     pkt_count_o
);

   replay_pkg::wr_state_e               state_q;
   logic [replay_pkg::ADDR_W-1:0]       wr_addr_q;
   logic                                at_top;
   logic                                accept_ok;
   logic                                beat_last;

   assign at_top    = (int'(wr_addr_q) == replay_pkg::DEPTH - 1);
   assign accept_ok = in_valid_i && !replay_busy_i && !clear_i;
   // the word in the top slot always closes the recording
   assign beat_last = in_beat_i.last || at_top;

   // a header write in progress counts as a partly recorded packet
   assign mid_packet_o = (state_q == replay_pkg::WR_DATA) ||
                         ((state_q == replay_pkg::WR_HEADER) && in_valid_i && !replay_busy_i);

   always_comb begin
      in_ready_o    = 1'b0;
      wr_valid_o    = 1'b0;
      wr_req_o      = '0;
      wr_req_o.addr = wr_addr_q;
      case (state_q)
         replay_pkg::WR_HEADER: begin
            // ready stays low here, the same beat is taken in the data state
            if (accept_ok && !at_top) begin
               wr_valid_o            = 1'b1;
               wr_req_o.word.head    = 1'b1;
               wr_req_o.word.payload = in_beat_i.user;
            end
         end
         replay_pkg::WR_DATA: begin
            in_ready_o = !replay_busy_i && !clear_i;
            if (accept_ok) begin
               wr_valid_o            = 1'b1;
               wr_req_o.word.last    = beat_last;
               wr_req_o.word.count   = replay_pkg::keep_to_count(in_beat_i.keep);
               wr_req_o.word.payload = in_beat_i.data;
            end
         end
         default: begin
            in_ready_o = !replay_busy_i && !clear_i;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         state_q     <= replay_pkg::WR_HEADER;
         wr_addr_q   <= '0;
         end_addr_o  <= '0;
         has_data_o  <= 1'b0;
         pkt_count_o <= '0;
      end else begin
         case (state_q)
            replay_pkg::WR_HEADER: begin
               if (accept_ok) begin
                  if (at_top) begin
                     state_q <= replay_pkg::WR_FLUSH;
                  end else begin
                     wr_addr_q   <= wr_addr_q + 1'b1;
                     pkt_count_o <= pkt_count_o + 32'd1;
                     state_q     <= replay_pkg::WR_DATA;
                  end
               end
            end
            replay_pkg::WR_DATA: begin
               if (accept_ok) begin
                  // end address only ever points at a finished packet
                  if (beat_last) begin
                     end_addr_o <= wr_addr_q;
                     has_data_o <= 1'b1;
                  end
                  if (at_top) begin
                     state_q <= replay_pkg::WR_FLUSH;
                  end else begin
                     wr_addr_q <= wr_addr_q + 1'b1;
                     if (in_beat_i.last) begin
                        state_q <= replay_pkg::WR_HEADER;
                     end
                  end
               end
            end
            default: begin
               state_q <= replay_pkg::WR_FLUSH;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/replay_pkg.sv
// ======================================
// Shared definitions for the packet
// record and replay engine: sizes, the
// stored word layout, stream and write
// request structs, and keep mask coding.
// Every module refers to these by
// scoped name.
// ======================================
`default_nettype none

package replay_pkg;

   localparam int DATA_BYTES = 16;
   localparam int DATA_W     = 128;
   localparam int USER_W     = 128;
   localparam int CNT_W      = 5;
   localparam int WORD_W     = 144;
   localparam int DEPTH      = 64;
   localparam int ADDR_W     = 6;
   localparam int PASS_W     = 8;
   localparam int CNT_LSB    = 128;
   localparam int LAST_BIT   = 135;
   localparam int HEAD_BIT   = 136;

   typedef enum logic [1:0] {WR_HEADER, WR_DATA, WR_FLUSH} wr_state_e;
   typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_e;

   typedef struct packed {
      logic [DATA_W-1:0]     data;
      logic [DATA_BYTES-1:0] keep;
      logic [USER_W-1:0]     user;
      logic                  last;
   } pkt_beat_t;

   // payload carries beat data, or the user field when head is set
   typedef struct packed {
      logic [WORD_W-HEAD_BIT-2:0]         zero_hi;
      logic                               head;
      logic                               last;
      logic [LAST_BIT-CNT_LSB-CNT_W-1:0]  zero_lo;
      logic [CNT_W-1:0]                   count;
      logic [CNT_LSB-1:0]                 payload;
   } mem_word_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      mem_word_t         word;
   } wr_req_t;

   // only masks filled from byte 0 upward have a count
   function automatic logic [CNT_W-1:0] keep_to_count(input logic [DATA_BYTES-1:0] keep);
      logic [CNT_W-1:0] count;
      count = '0;
      for (int n = 1; n <= DATA_BYTES; n++) begin
         if (keep == ({DATA_BYTES{1'b1}} >> (DATA_BYTES - n))) begin
            count = CNT_W'(n);
         end
      end
      return count;
   endfunction

   function automatic logic [DATA_BYTES-1:0] count_to_keep(input logic [CNT_W-1:0] count);
      logic [DATA_BYTES-1:0] keep;
      keep = '0;
      for (int n = 1; n <= DATA_BYTES; n++) begin
         if (count == CNT_W'(n)) begin
            keep = {DATA_BYTES{1'b1}} >> (DATA_BYTES - n);
         end
      end
      return keep;
   endfunction

endpackage

`default_nettype wire

// File: verilog/replay_sequencer.sv
// ======================================
// Replay read sequencer. On start it
// walks the store from address zero to
// the recorded end address, once per
// requested pass, issuing one read per
// cycle while the unpacker has room.
// ======================================
`default_nettype none

module replay_sequencer (
   input  wire                             clk,
   input  wire                             rst_clk,
   input  wire                             clear_i,
   input  wire                             start_i,
   input  wire [replay_pkg::PASS_W-1:0]    pass_count_i,
   input  wire [replay_pkg::ADDR_W-1:0]    end_addr_i,
   input  wire                             has_data_i,
   input  wire                             mid_packet_i,
   input  wire                             word_room_i,
   input  wire                             rd_ready_i,
   output logic [replay_pkg::ADDR_W-1:0]   rd_addr_o,
   output logic                            rd_valid_o,
   output logic                            busy_o
);

   replay_pkg::seq_state_e              state_q;
   logic [replay_pkg::PASS_W-1:0]       pass_target_q;
   logic [replay_pkg::PASS_W-1:0]       pass_done_q;
   logic                                issue;
   logic                                at_end;
   logic                                last_pass;
   logic                                can_start;

   assign busy_o     = (state_q == replay_pkg::SEQ_RUN);
   // the unpacker credit already covers the read that is in flight
   assign rd_valid_o = busy_o && word_room_i;
   assign issue      = rd_valid_o && rd_ready_i;
   assign at_end     = (rd_addr_o == end_addr_i);
   assign last_pass  = (pass_done_q == pass_target_q - 1'b1);

   // a zero pass count has nothing to replay and is ignored
   assign can_start = start_i && has_data_i && !mid_packet_i && (pass_count_i != '0);

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         state_q       <= replay_pkg::SEQ_IDLE;
         rd_addr_o     <= '0;
         pass_done_q   <= '0;
         pass_target_q <= '0;
      end else begin
         case (state_q)
            replay_pkg::SEQ_IDLE: begin
               if (can_start) begin
                  state_q       <= replay_pkg::SEQ_RUN;
                  rd_addr_o     <= '0;
                  pass_done_q   <= '0;
                  pass_target_q <= pass_count_i;
               end
            end
            default: begin
               if (issue) begin
                  if (at_end) begin
                     rd_addr_o   <= '0;
                     pass_done_q <= pass_done_q + 1'b1;
                     if (last_pass) begin
                        state_q <= replay_pkg::SEQ_IDLE;
                     end
                  end else begin
                     rd_addr_o <= rd_addr_o + 1'b1;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/stream_unpacker.sv
// ======================================
// Turns words read from the store back
// into stream beats. Header words load
// the user field for the next beat and
// give no output. A small buffer absorbs
// output back-pressure and returns room
// as a credit to the read sequencer.
// ======================================
`default_nettype none

module stream_unpacker (
   input  wire                          clk,
   input  wire                          rst_clk,
   input  wire replay_pkg::mem_word_t   word_i,
   input  wire                          word_valid_i,
   output logic                         word_room_o,
   output replay_pkg::pkt_beat_t        out_beat_o,
   output logic                         out_valid_o,
   input  wire                          out_ready_i
);

   replay_pkg::mem_word_t            word_buf_q [4];
   logic [1:0]                       wr_ptr_q;
   logic [1:0]                       rd_ptr_q;
   logic [2:0]                       fill_q;
   logic [replay_pkg::USER_W-1:0]    user_q;
   replay_pkg::mem_word_t            head_word;
   logic                             pop;

   assign head_word = word_buf_q[rd_ptr_q];

   // two free slots, one for a read in flight and one for a new read
   assign word_room_o = (fill_q <= 3'd2);

   assign out_valid_o = (fill_q != 3'd0) && !head_word.head;
   assign pop         = (fill_q != 3'd0) && (head_word.head || out_ready_i);

   always_comb begin
      out_beat_o.data = head_word.payload;
      out_beat_o.keep = replay_pkg::count_to_keep(head_word.count);
      out_beat_o.user = user_q;
      out_beat_o.last = head_word.last;
   end

   always_ff @(posedge clk) begin
      if (word_valid_i) begin
         word_buf_q[wr_ptr_q] <= word_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         user_q   <= '0;
      end else begin
         if (word_valid_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
            // user field rides on the first beat only
            user_q   <= head_word.head ? head_word.payload : '0;
         end
         fill_q <= fill_q + {2'b00, word_valid_i} - {2'b00, pop};
      end
   end

endmodule

`default_nettype wire

// File: verilog/word_store.sv
// ======================================
// On-chip word store shared by the
// recorder and the replay path. Writes
// always win, a read is taken only in a
// cycle without a write, and read data
// returns on the following cycle.
// ======================================
`default_nettype none

module word_store (
   input  wire                             clk,
   input  wire replay_pkg::wr_req_t        wr_req_i,
   input  wire                             wr_valid_i,
   input  wire [replay_pkg::ADDR_W-1:0]    rd_addr_i,
   input  wire                             rd_valid_i,
   output logic                            rd_ready_o,
   output replay_pkg::mem_word_t           rd_word_o,
   output logic                            word_valid_o
);

   replay_pkg::mem_word_t   mem_q [replay_pkg::DEPTH];
   logic                    rd_fire;

   // the array has a single port, so a write blocks the read that cycle
   assign rd_ready_o = !wr_valid_i;
   assign rd_fire    = rd_valid_i && rd_ready_o;

   always_ff @(posedge clk) begin
      if (wr_valid_i) begin
         mem_q[wr_req_i.addr] <= wr_req_i.word;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         rd_word_o <= mem_q[rd_addr_i];
      end
   end

   // follows the read request by exactly one cycle
   always_ff @(posedge clk) begin
      word_valid_o <= rd_fire;
   end

endmodule

`default_nettype wire
